//--- hdl/link_hub_pkg.sv
package link_hub_pkg;

  // ==========================================================================
  // lane geometry
  // ==========================================================================
  localparam int NUM_LANES = 7;

  typedef logic [31:0]          word_t;
  typedef logic [3:0]           kchar_t;
  typedef logic [NUM_LANES-1:0] lane_mask_t;

  // one lane word as handed to the transceiver
  typedef struct packed {
    logic   valid;
    word_t  data;
    kchar_t kchar;
  } lane_word_t;

  // ==========================================================================
  // host register bus
  // ==========================================================================
  typedef logic [3:0]  wb_addr_t;
  typedef logic [31:0] reg_data_t;

  // wishbone classic request, master to slave
  typedef struct packed {
    logic       cyc;
    logic       stb;
    logic       we;
    wb_addr_t   adr;
    reg_data_t  dat;
    logic [3:0] sel;
  } wb_req_t;

  // bit 0 receive, bit 1 send
  typedef logic [1:0] irq_vec_t;

  // loop channel test word and its replacement on the wire
  localparam word_t LOOP_TEST_WORD  = 32'h0000_0001;
  localparam word_t TEST_SUBST_WORD = 32'h0001_0000;

  // register map, word addresses
  localparam wb_addr_t REG_SOFT_RSTN   = 4'd0;
  localparam wb_addr_t REG_TEST_FLAG   = 4'd1;
  localparam wb_addr_t REG_LINK_STATUS = 4'd2;
  localparam wb_addr_t REG_SEND_CNT    = 4'd3;
  localparam wb_addr_t REG_RECV_CNT    = 4'd4;
  localparam wb_addr_t REG_IRQ_ACK     = 4'd5;
  localparam wb_addr_t REG_IRQ_PEND    = 4'd6;

  localparam lane_mask_t SOFT_RSTN_INIT = '1;

endpackage

//--- hdl/irq_ctrl.sv
`timescale 1ns/10ps

module irq_ctrl (
  input  logic                   kernel_clk,
  input  logic                   kernel_rstn,
  input  link_hub_pkg::irq_vec_t kernel_irq,
  input  link_hub_pkg::irq_vec_t irq_ack,
  output link_hub_pkg::irq_vec_t irq_pend,
  output link_hub_pkg::irq_vec_t host_irq_req,
  output link_hub_pkg::irq_vec_t kernel_ack
);

  link_hub_pkg::irq_vec_t pend;
  link_hub_pkg::irq_vec_t ack_q;
  link_hub_pkg::irq_vec_t pend_next;

  // ==========================================================================
  // pending bits
  // ==========================================================================
  // a new event wins over an ack in the same cycle
  assign pend_next = (pend & ~irq_ack) | kernel_irq;

  always_ff @(posedge kernel_clk or posedge kernel_rstn) begin
    if (kernel_rstn) begin
      pend <= '0;
    end else begin
      pend <= pend_next;
    end
  end

  assign irq_pend     = pend;
  assign host_irq_req = pend;

  // ==========================================================================
  // kernel acknowledge
  // ==========================================================================
  // only bits that were actually pending get acked back
  always_ff @(posedge kernel_clk or posedge kernel_rstn) begin
    if (kernel_rstn) begin
      ack_q <= '0;
    end else begin
      ack_q <= irq_ack & pend;
    end
  end

  assign kernel_ack = ack_q;

  // no kernel ack for an event that was never raised to the host
  for (genvar i = 0; i < $bits(link_hub_pkg::irq_vec_t); i++) begin : g_ack_chk
    a_ack_pending: assert property (
      @(posedge kernel_clk) disable iff (kernel_rstn)
      kernel_ack[i] |-> $past(pend[i])
    );
  end

endmodule

//--- hdl/lane_port.sv
`timescale 1ns/10ps

module lane_port (
  input  logic                     kernel_clk,
  input  logic                     kernel_rstn,
  input  link_hub_pkg::lane_word_t tx_in,
  input  logic                     link_ready,
  input  logic                     soft_rstn,
  input  logic                     test_flag,
  output link_hub_pkg::lane_word_t tx_out
);

  logic                 lane_en;
  logic                 out_valid;
  link_hub_pkg::word_t  out_data;
  link_hub_pkg::kchar_t out_kchar;
  link_hub_pkg::word_t  next_data;

  // lane runs only with the link up and out of soft reset
  assign lane_en = link_ready & soft_rstn;

  // ==========================================================================
  // test word substitution
  // ==========================================================================
  // kchar is left alone
  assign next_data = (test_flag && tx_in.data == link_hub_pkg::LOOP_TEST_WORD) ?
                     link_hub_pkg::TEST_SUBST_WORD : tx_in.data;

  // ==========================================================================
  // output stage
  // ==========================================================================
  always_ff @(posedge kernel_clk or posedge kernel_rstn) begin
    if (kernel_rstn) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= tx_in.valid & lane_en;
    end
  end

  always_ff @(posedge kernel_clk) begin
    out_data  <= next_data;
    out_kchar <= tx_in.kchar;
  end

  assign tx_out.valid = out_valid;
  assign tx_out.data  = out_data;
  assign tx_out.kchar = out_kchar;

  // a word only leaves a lane that was enabled when it came in
  a_valid_enabled: assert property (
    @(posedge kernel_clk) disable iff (kernel_rstn)
    tx_out.valid |-> $past(lane_en)
  );

endmodule

//--- hdl/ctrl_regs.sv
`timescale 1ns/10ps

module ctrl_regs #(
  parameter int NUM_LANES = link_hub_pkg::NUM_LANES
) (
  input  logic                      kernel_clk,
  input  logic                      kernel_rstn,
  input  link_hub_pkg::wb_req_t     wb_req,
  output logic                      wb_ack,
  output link_hub_pkg::reg_data_t   wb_dat_r,
  input  link_hub_pkg::lane_mask_t  link_ready,
  input  logic                      send_beat,
  input  logic                      recv_beat,
  input  link_hub_pkg::irq_vec_t    irq_pend,
  output link_hub_pkg::lane_mask_t  soft_rstn,
  output logic                      test_flag,
  output link_hub_pkg::irq_vec_t    irq_ack
);

  // bus cycle: sample, ack, one dead cycle
  typedef enum logic [1:0] {
    BUS_IDLE,
    BUS_ACK,
    BUS_GAP
  } bus_state_e;

  bus_state_e               state;
  logic                     req;
  logic                     wr_en;
  link_hub_pkg::reg_data_t  cur_word;
  link_hub_pkg::reg_data_t  wr_word;
  link_hub_pkg::reg_data_t  rd_data;
  link_hub_pkg::reg_data_t  send_cnt;
  link_hub_pkg::reg_data_t  recv_cnt;

  // keep the bytes not selected by sel
  function automatic link_hub_pkg::reg_data_t byte_merge(
    input link_hub_pkg::reg_data_t old_word,
    input link_hub_pkg::reg_data_t new_word,
    input logic [3:0]              sel
  );
    link_hub_pkg::reg_data_t res;
    res = old_word;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        res[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return res;
  endfunction

  // ==========================================================================
  // wishbone classic slave
  // ==========================================================================
  assign req    = wb_req.cyc & wb_req.stb;
  assign wb_ack = (state == BUS_ACK);
  // master still holds the request while ack is up
  assign wr_en  = wb_ack & req & wb_req.we;

  always_ff @(posedge kernel_clk or posedge kernel_rstn) begin
    if (kernel_rstn) begin
      state <= BUS_IDLE;
    end else begin
      case (state)
        BUS_IDLE: if (req) state <= BUS_ACK;
        BUS_ACK:  state <= BUS_GAP;
        default:  state <= BUS_IDLE;
      endcase
    end
  end

  // current contents of the addressed register
  always_comb begin
    cur_word = '0;
    case (wb_req.adr)
      link_hub_pkg::REG_SOFT_RSTN:   cur_word[NUM_LANES-1:0] = soft_rstn;
      link_hub_pkg::REG_TEST_FLAG:   cur_word[0] = test_flag;
      link_hub_pkg::REG_LINK_STATUS: cur_word[NUM_LANES-1:0] = link_ready;
      link_hub_pkg::REG_SEND_CNT:    cur_word = send_cnt;
      link_hub_pkg::REG_RECV_CNT:    cur_word = recv_cnt;
      link_hub_pkg::REG_IRQ_PEND:    cur_word[1:0] = irq_pend;
      // irq ack is write only
      default:                       cur_word = '0;
    endcase
  end

  assign wr_word = byte_merge(cur_word, wb_req.dat, wb_req.sel);

  // read data captured when the request is sampled
  always_ff @(posedge kernel_clk) begin
    if (state == BUS_IDLE && req) begin
      rd_data <= cur_word;
    end
  end

  assign wb_dat_r = rd_data;

  // ==========================================================================
  // control registers
  // ==========================================================================
  always_ff @(posedge kernel_clk or posedge kernel_rstn) begin
    if (kernel_rstn) begin
      soft_rstn <= link_hub_pkg::SOFT_RSTN_INIT;
      test_flag <= 1'b0;
      irq_ack   <= '0;
    end else begin
      irq_ack <= '0;
      if (wr_en) begin
        case (wb_req.adr)
          link_hub_pkg::REG_SOFT_RSTN: soft_rstn <= wr_word[NUM_LANES-1:0];
          link_hub_pkg::REG_TEST_FLAG: test_flag <= wr_word[0];
          link_hub_pkg::REG_IRQ_ACK:   irq_ack   <= wr_word[1:0];
          default: ;
        endcase
      end
    end
  end

  // host stream beat counters, wrap at 2^32
  always_ff @(posedge kernel_clk or posedge kernel_rstn) begin
    if (kernel_rstn) begin
      send_cnt <= '0;
      recv_cnt <= '0;
    end else begin
      if (send_beat) send_cnt <= send_cnt + 1'b1;
      if (recv_beat) recv_cnt <= recv_cnt + 1'b1;
    end
  end

  // ack is a single-cycle pulse followed by a dead cycle
  a_ack_single: assert property (
    @(posedge kernel_clk) disable iff (kernel_rstn)
    wb_ack |=> !wb_ack
  );

endmodule

//--- hdl/link_hub_top.sv
`timescale 1ns/10ps

module link_hub_top #(
  parameter int NUM_LANES = link_hub_pkg::NUM_LANES
) (
  input  logic                                        kernel_clk,
  input  logic                                        kernel_rstn,

  // host register bus
  input  link_hub_pkg::wb_req_t                       wb_req,
  output logic                                        wb_ack,
  output link_hub_pkg::reg_data_t                     wb_dat_r,

  // lane words from the kernels, toward the transceivers
  input  link_hub_pkg::lane_word_t [NUM_LANES-1:0]    lane_tx_in,
  output link_hub_pkg::lane_word_t [NUM_LANES-1:0]    lane_tx_out,
  input  link_hub_pkg::lane_mask_t                    link_ready,

  // host stream beat strobes
  input  logic                                        send_beat,
  input  logic                                        recv_beat,

  // interrupts
  input  link_hub_pkg::irq_vec_t                      kernel_irq,
  output link_hub_pkg::irq_vec_t                      kernel_ack,
  output link_hub_pkg::irq_vec_t                      host_irq_req
);

  link_hub_pkg::lane_mask_t soft_rstn;
  logic                     test_flag;
  link_hub_pkg::irq_vec_t   irq_ack;
  link_hub_pkg::irq_vec_t   irq_pend;

  // ==========================================================================
  // host registers
  // ==========================================================================
  ctrl_regs #(
    .NUM_LANES (NUM_LANES)
  ) u_ctrl_regs (
    .kernel_clk  (kernel_clk),
    .kernel_rstn (kernel_rstn),
    .wb_req      (wb_req),
    .wb_ack      (wb_ack),
    .wb_dat_r    (wb_dat_r),
    .link_ready  (link_ready),
    .send_beat   (send_beat),
    .recv_beat   (recv_beat),
    .irq_pend    (irq_pend),
    .soft_rstn   (soft_rstn),
    .test_flag   (test_flag),
    .irq_ack     (irq_ack)
  );

  // ==========================================================================
  // interrupt handshake
  // ==========================================================================
  irq_ctrl u_irq_ctrl (
    .kernel_clk   (kernel_clk),
    .kernel_rstn  (kernel_rstn),
    .kernel_irq   (kernel_irq),
    .irq_ack      (irq_ack),
    .irq_pend     (irq_pend),
    .host_irq_req (host_irq_req),
    .kernel_ack   (kernel_ack)
  );

  // ==========================================================================
  // lane transmit stages
  // ==========================================================================
  // lanes 0..5 carry the serial-link kernels, the last one the host loop
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    lane_port u_lane_port (
      .kernel_clk  (kernel_clk),
      .kernel_rstn (kernel_rstn),
      .tx_in       (lane_tx_in[i]),
      .link_ready  (link_ready[i]),
      .soft_rstn   (soft_rstn[i]),
      .test_flag   (test_flag),
      .tx_out      (lane_tx_out[i])
    );
  end

endmodule

//--- verif/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen #(
  parameter int  RESET_CYCLES = 16,
  parameter real HALF_PERIOD  = 10.0
) (
  output logic kernel_clk,
  output logic kernel_rstn
);

  initial begin
    kernel_clk = 1'b0;
    forever #(HALF_PERIOD) kernel_clk = ~kernel_clk;
  end

  // reset is active high, released on a falling edge
  initial begin
    kernel_rstn = 1'b1;
    repeat (RESET_CYCLES) @(posedge kernel_clk);
    @(negedge kernel_clk);
    kernel_rstn = 1'b0;
  end

endmodule

//--- verif/tb_link_hub.sv
`timescale 1ns/10ps

module tb_link_hub;

  localparam int NUM_LANES = link_hub_pkg::NUM_LANES;

  // rough cycle budget per test
  localparam int LEN_RESET  = 16 + 40;
  localparam int LEN_PASS   = 12;
  localparam int LEN_SUBST  = 30;
  localparam int LEN_GATE   = 40;
  localparam int LEN_COUNT  = 35;
  localparam int LEN_IRQ    = 40;
  localparam int TIMEOUT_CYCLES =
    2 * (LEN_RESET + LEN_PASS + LEN_SUBST + LEN_GATE + LEN_COUNT + LEN_IRQ);

  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  logic                                         kernel_clk;
  logic                                         kernel_rstn;
  link_hub_pkg::wb_req_t                        wb_req;
  logic                                         wb_ack;
  link_hub_pkg::reg_data_t                      wb_dat_r;
  link_hub_pkg::lane_word_t [NUM_LANES-1:0]     lane_tx_in;
  link_hub_pkg::lane_word_t [NUM_LANES-1:0]     lane_tx_out;
  link_hub_pkg::lane_mask_t                     link_ready;
  logic                                         send_beat;
  logic                                         recv_beat;
  link_hub_pkg::irq_vec_t                       kernel_irq;
  link_hub_pkg::irq_vec_t                       kernel_ack;
  link_hub_pkg::irq_vec_t                       host_irq_req;

  logic [31:0] lfsr = 32'd95;
  int          cycles = 0;
  int          ack_seen [2] = '{0, 0};

  tb_clk_gen u_clk_gen (
    .kernel_clk  (kernel_clk),
    .kernel_rstn (kernel_rstn)
  );

  link_hub_top #(
    .NUM_LANES (NUM_LANES)
  ) DUT (
    .kernel_clk   (kernel_clk),
    .kernel_rstn  (kernel_rstn),
    .wb_req       (wb_req),
    .wb_ack       (wb_ack),
    .wb_dat_r     (wb_dat_r),
    .lane_tx_in   (lane_tx_in),
    .lane_tx_out  (lane_tx_out),
    .link_ready   (link_ready),
    .send_beat    (send_beat),
    .recv_beat    (recv_beat),
    .kernel_irq   (kernel_irq),
    .kernel_ack   (kernel_ack),
    .host_irq_req (host_irq_req)
  );

  // ==========================================================================
  // helpers
  // ==========================================================================
  // galois lfsr, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
      val  = {val[30:0], lfsr[0]};
    end
    return val;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
      $display("Testbench failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // one classic cycle, request held until ack has been seen
  task automatic wb_access(input logic we, input link_hub_pkg::wb_addr_t adr,
                           input link_hub_pkg::reg_data_t wdat,
                           output link_hub_pkg::reg_data_t rdat);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = wdat;
    wb_req.sel = 4'hf;
    @(negedge kernel_clk);
    while (!wb_ack) @(negedge kernel_clk);
    rdat = wb_dat_r;
    @(negedge kernel_clk);
    // ack lasts a single cycle
    check_val("wb_ack", 32'd0, 32'(wb_ack));
    wb_req = '0;
  endtask

  task automatic read_check(input link_hub_pkg::wb_addr_t adr,
                            input link_hub_pkg::reg_data_t exp, input string name);
    link_hub_pkg::reg_data_t rd;
    wb_access(1'b0, adr, '0, rd);
    check_val(name, exp, rd);
  endtask

  task automatic reg_write(input link_hub_pkg::wb_addr_t adr,
                           input link_hub_pkg::reg_data_t dat);
    link_hub_pkg::reg_data_t unused;
    wb_access(1'b1, adr, dat, unused);
  endtask

  // words on every lane, checked one cycle later
  task automatic lane_burst(input int n, input logic subst, input link_hub_pkg::lane_mask_t en);
    link_hub_pkg::lane_word_t [NUM_LANES-1:0] sent;
    link_hub_pkg::lane_word_t                 w;
    link_hub_pkg::word_t                      exp_data;
    for (int c = 0; c < n; c++) begin
      for (int i = 0; i < NUM_LANES; i++) begin
        w.valid = 1'b1;
        w.data  = (i == c % NUM_LANES) ? link_hub_pkg::LOOP_TEST_WORD : rand_bits(32);
        w.kchar = link_hub_pkg::kchar_t'(rand_bits(4));
        lane_tx_in[i] = w;
      end
      sent = lane_tx_in;
      @(negedge kernel_clk);
      for (int i = 0; i < NUM_LANES; i++) begin
        check_val($sformatf("lane_tx_out[%0d].valid", i), 32'(en[i]),
                  32'(lane_tx_out[i].valid));
        if (en[i]) begin
          exp_data = sent[i].data;
          if (subst && i == c % NUM_LANES) exp_data = link_hub_pkg::TEST_SUBST_WORD;
          check_val($sformatf("lane_tx_out[%0d].data", i), exp_data, lane_tx_out[i].data);
          check_val($sformatf("lane_tx_out[%0d].kchar", i), 32'(sent[i].kchar),
                    32'(lane_tx_out[i].kchar));
        end
      end
    end
    lane_tx_in = '0;
  endtask

  // ==========================================================================
  // tests
  // ==========================================================================
  task automatic reset_values();
    for (int i = 0; i < NUM_LANES; i++) begin
      check_val($sformatf("lane_tx_out[%0d].valid", i), 32'd0, 32'(lane_tx_out[i].valid));
    end
    check_val("host_irq_req", 32'd0, 32'(host_irq_req));
    check_val("kernel_ack", 32'd0, 32'(kernel_ack));
    read_check(link_hub_pkg::REG_SOFT_RSTN, 32'(link_hub_pkg::SOFT_RSTN_INIT), "soft_rstn");
    read_check(link_hub_pkg::REG_TEST_FLAG, 32'd0, "test_flag");
    read_check(link_hub_pkg::REG_SEND_CNT, 32'd0, "send_cnt");
    read_check(link_hub_pkg::REG_RECV_CNT, 32'd0, "recv_cnt");
    read_check(link_hub_pkg::REG_IRQ_PEND, 32'd0, "irq_pend");
  endtask

  task automatic word_substitution();
    reg_write(link_hub_pkg::REG_TEST_FLAG, 32'd1);
    read_check(link_hub_pkg::REG_TEST_FLAG, 32'd1, "test_flag");
    lane_burst(8, 1'b1, '1);
    reg_write(link_hub_pkg::REG_TEST_FLAG, 32'd0);
  endtask

  task automatic gating_and_status();
    link_hub_pkg::lane_mask_t mask;
    mask = ~link_hub_pkg::lane_mask_t'(7'b000_0100);
    reg_write(link_hub_pkg::REG_SOFT_RSTN, 32'(mask));
    lane_burst(4, 1'b0, mask);
    reg_write(link_hub_pkg::REG_SOFT_RSTN, 32'(link_hub_pkg::SOFT_RSTN_INIT));
    // now drop one link instead
    link_ready = ~link_hub_pkg::lane_mask_t'(7'b010_0000);
    read_check(link_hub_pkg::REG_LINK_STATUS, 32'(link_ready), "link_status");
    lane_burst(4, 1'b0, link_ready);
    link_ready = '1;
  endtask

  task automatic beat_counters();
    int n_send;
    int n_recv;
    n_send = int'(rand_bits(4)) + 1;
    n_recv = int'(rand_bits(4)) + 1;
    // distinct counts so a swapped counter shows
    if (n_recv == n_send) n_recv = n_send % 16 + 1;
    for (int c = 0; c < 17; c++) begin
      send_beat = (c < n_send);
      recv_beat = (c < n_recv);
      @(negedge kernel_clk);
    end
    send_beat = 1'b0;
    recv_beat = 1'b0;
    @(negedge kernel_clk);
    read_check(link_hub_pkg::REG_SEND_CNT, 32'(n_send), "send_cnt");
    read_check(link_hub_pkg::REG_RECV_CNT, 32'(n_recv), "recv_cnt");
  endtask

  task automatic irq_handshake(input int b);
    link_hub_pkg::irq_vec_t src;
    int                     base [2];
    src = link_hub_pkg::irq_vec_t'(2'b01 << b);
    kernel_irq = src;
    @(negedge kernel_clk);
    kernel_irq = '0;
    check_val("host_irq_req", 32'(src), 32'(host_irq_req));
    read_check(link_hub_pkg::REG_IRQ_PEND, 32'(src), "irq_pend");
    base = ack_seen;
    reg_write(link_hub_pkg::REG_IRQ_ACK, 32'(src));
    repeat (3) @(negedge kernel_clk);
    check_val("host_irq_req", 32'd0, 32'(host_irq_req));
    check_val("kernel_ack[0] pulses", (b == 0) ? 32'd1 : 32'd0, 32'(ack_seen[0] - base[0]));
    check_val("kernel_ack[1] pulses", (b == 1) ? 32'd1 : 32'd0, 32'(ack_seen[1] - base[1]));
  endtask

  // ==========================================================================
  // monitors and run control
  // ==========================================================================
  always @(negedge kernel_clk) begin
    if (kernel_ack[0]) ack_seen[0]++;
    if (kernel_ack[1]) ack_seen[1]++;
  end

  always @(posedge kernel_clk) begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("timeout: tests did not finish");
      $display("Testbench failed");
      $fatal(1, "cycle limit reached");
    end
  end

  initial begin
    wb_req     = '0;
    lane_tx_in = '0;
    link_ready = '1;
    send_beat  = 1'b0;
    recv_beat  = 1'b0;
    kernel_irq = '0;
    @(negedge kernel_clk);
    while (kernel_rstn) @(negedge kernel_clk);
    @(negedge kernel_clk);
    reset_values();
    lane_burst(8, 1'b0, '1);
    word_substitution();
    gating_and_status();
    beat_counters();
    irq_handshake(0);
    irq_handshake(1);
    $display("Testbench passed");
    $finish;
  end

endmodule

//--- project.f
hdl/link_hub_pkg.sv
hdl/irq_ctrl.sv
hdl/lane_port.sv
hdl/ctrl_regs.sv
hdl/link_hub_top.sv
verif/tb_clk_gen.sv
verif/tb_link_hub.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the link hub testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_link_hub -f project.f --Mdir "$OBJ" -o tb_link_hub
if [ $? -ne 0 ]; then
  echo "run_sim: verilator build failed"
  exit 1
fi

"./$OBJ/tb_link_hub" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Testbench failed" "$LOG"; then
  echo "run_sim: simulation reported failure"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "run_sim: simulator exited with status $status"
  exit 1
fi

echo "run_sim: simulation ok"
exit 0
